// File: rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // Datapath and lane sizing
    localparam int DATA_W     = 32;
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;
    localparam int OP_W       = 4;

    // Operation codes, 14 and 15 give an all-zero result
    localparam logic [OP_W-1:0] OP_ADD = 4'd0;
    localparam logic [OP_W-1:0] OP_SUB = 4'd1;
    localparam logic [OP_W-1:0] OP_NEG = 4'd2;
    localparam logic [OP_W-1:0] OP_OR  = 4'd3;
    localparam logic [OP_W-1:0] OP_XOR = 4'd4;
    localparam logic [OP_W-1:0] OP_AND = 4'd5;
    localparam logic [OP_W-1:0] OP_MUL = 4'd6;
    localparam logic [OP_W-1:0] OP_DIV = 4'd7;
    localparam logic [OP_W-1:0] OP_SLL = 4'd8;
    localparam logic [OP_W-1:0] OP_SRL = 4'd9;
    localparam logic [OP_W-1:0] OP_SRA = 4'd10;
    localparam logic [OP_W-1:0] OP_ROR = 4'd11;
    localparam logic [OP_W-1:0] OP_ROL = 4'd12;
    localparam logic [OP_W-1:0] OP_NOT = 4'd13;

    // 64-bit lane result
    // Multiply reads it as one product, divide as quotient (hi) and remainder (lo)
    typedef union packed {
        logic [2*DATA_W-1:0] prod;
        struct packed {
            logic [DATA_W-1:0] hi;
            logic [DATA_W-1:0] lo;
        } pair;
    } alu_result_u;

endpackage

`default_nettype wire

// File: rtl/alu_lane_if.sv
`timescale 1ns/1ns
`default_nettype none

interface alu_lane_if;

    // Issue side
    logic                             start;
    logic [alu_pkg::OP_W-1:0]         op;
    logic [alu_pkg::DATA_W-1:0]       a;
    logic [alu_pkg::DATA_W-1:0]       b;

    // Lane status and result
    logic                             busy;
    logic                             done;
    alu_pkg::alu_result_u             result;
    logic                             zero;
    logic                             neg;

    // Collector frees the lane
    logic                             rel;

    modport dispatch (output start, op, a, b, input busy);
    modport lane (input start, op, a, b, rel, output busy, done, result, zero, neg);
    modport collect (input done, result, zero, neg, output rel);

endinterface

`default_nettype wire

// File: rtl/alu_core.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core (
    input  wire logic [alu_pkg::OP_W-1:0]   op,
    input  wire logic [alu_pkg::DATA_W-1:0] a,
    input  wire logic [alu_pkg::DATA_W-1:0] b,
    output alu_pkg::alu_result_u            result,
    output logic                            zero,
    output logic                            neg
);

    localparam int W = alu_pkg::DATA_W;

    logic [W-1:0]   add_a;
    logic [W-1:0]   add_b;
    logic           add_cin;
    logic [W-1:0]   sum;

    logic [W-1:0]   fun_hi;
    logic [W-1:0]   fun_lo;
    logic [5:0]     fun_sh;
    logic [2*W-1:0] fun_wide;
    logic [W-1:0]   sft_out;
    logic [W-1:0]   sra_fill;

    logic [2*W-1:0] prod;
    logic           is_arith;

    // Shared adder: subtract is a + ~b + 1, negate is 0 + ~a + 1
    assign add_a   = (op == alu_pkg::OP_NEG) ? '0 : a;
    assign add_b   = (op == alu_pkg::OP_SUB) ? ~b :
                     (op == alu_pkg::OP_NEG) ? ~a : b;
    assign add_cin = (op == alu_pkg::OP_SUB) || (op == alu_pkg::OP_NEG);
    assign sum     = add_a + add_b + W'(add_cin);

    // Funnel shifter for all shifts and rotates
    // Left moves become right moves of {a, lo} by 32 - amount
    assign sra_fill = {W{a[W-1]}};

    always_comb begin
        fun_hi = '0;
        fun_lo = a;
        fun_sh = {1'b0, b[4:0]};
        case (op)
            alu_pkg::OP_SRA: begin
                fun_hi = sra_fill;
            end
            alu_pkg::OP_ROR: begin
                fun_hi = a;
            end
            alu_pkg::OP_SLL: begin
                fun_hi = a;
                fun_lo = '0;
                fun_sh = 6'd32 - {1'b0, b[4:0]};
            end
            alu_pkg::OP_ROL: begin
                fun_hi = a;
                fun_sh = 6'd32 - {1'b0, b[4:0]};
            end
            default: begin
                fun_hi = '0;
            end
        endcase
    end

    assign fun_wide = {fun_hi, fun_lo} >> fun_sh;
    assign sft_out  = fun_wide[W-1:0];

    // Operands taken as unsigned
    assign prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};

    always_comb begin
        result = '0;
        case (op)
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB,
            alu_pkg::OP_NEG: result.pair.lo = sum;
            alu_pkg::OP_OR:  result.pair.lo = a | b;
            alu_pkg::OP_XOR: result.pair.lo = a ^ b;
            alu_pkg::OP_AND: result.pair.lo = a & b;
            alu_pkg::OP_MUL: result.prod    = prod;
            alu_pkg::OP_SLL,
            alu_pkg::OP_SRL,
            alu_pkg::OP_SRA,
            alu_pkg::OP_ROR,
            alu_pkg::OP_ROL: result.pair.lo = sft_out;
            alu_pkg::OP_NOT: result.pair.lo = ~a;
            // Divide handled by the lane's divider
            default:         result = '0;
        endcase
    end

    assign is_arith = (op == alu_pkg::OP_ADD) || (op == alu_pkg::OP_SUB) ||
                      (op == alu_pkg::OP_NEG);

    assign neg  = is_arith                ? sum[W-1] :
                  (op == alu_pkg::OP_MUL) ? prod[2*W-1] :
                  result.pair.lo[W-1];
    assign zero = (result.prod == '0);

endmodule

`default_nettype wire

// File: rtl/alu_divider.sv
`timescale 1ns/1ns
`default_nettype none

module alu_divider (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       start,
    input  wire logic [alu_pkg::DATA_W-1:0] a,
    input  wire logic [alu_pkg::DATA_W-1:0] b,
    output alu_pkg::alu_result_u            result,
    output logic                            neg,
    output logic                            done
);

    localparam int W = alu_pkg::DATA_W;

    logic [W-1:0] a_mag;
    logic [W-1:0] b_mag;
    logic [W-1:0] rem_q;
    logic [W-1:0] quo_q;
    logic [W-1:0] div_q;
    logic         a_neg_q;
    logic         q_neg_q;
    logic         running;
    logic [4:0]   cnt;

    // One restoring step, returns {remainder, quotient}
    function automatic logic [2*W-1:0] div_step(
        input logic [W-1:0] rem,
        input logic [W-1:0] quo,
        input logic [W-1:0] d
    );
        logic [W:0] shifted;
        logic [W:0] diff;
        shifted = {rem, quo[W-1]};
        diff    = shifted - {1'b0, d};
        if (shifted >= {1'b0, d}) begin
            return {diff[W-1:0], quo[W-2:0], 1'b1};
        end
        return {shifted[W-1:0], quo[W-2:0], 1'b0};
    endfunction

    assign a_mag = a[W-1] ? -a : a;
    assign b_mag = b[W-1] ? -b : b;

    // First step runs on the start edge, 31 more follow
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= 5'd31;
            end else if (running) begin
                cnt <= cnt - 5'd1;
                if (cnt == 5'd1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            {rem_q, quo_q} <= div_step('0, a_mag, b_mag);
            div_q          <= b_mag;
            a_neg_q        <= a[W-1];
            q_neg_q        <= a[W-1] ^ b[W-1];
        end else if (running) begin
            {rem_q, quo_q} <= div_step(rem_q, quo_q, div_q);
        end
    end

    // Quotient negated on differing signs, remainder follows the dividend
    always_comb begin
        result.pair.hi = q_neg_q ? -quo_q : quo_q;
        result.pair.lo = a_neg_q ? -rem_q : rem_q;
    end

    assign neg = q_neg_q;

endmodule

`default_nettype wire

// File: rtl/alu_lane.sv
`timescale 1ns/1ns
`default_nettype none

module alu_lane (
    input wire logic clk,
    input wire logic rst_n,
    alu_lane_if.lane lane
);

    logic [alu_pkg::OP_W-1:0]   op_q;
    logic [alu_pkg::DATA_W-1:0] a_q;
    logic [alu_pkg::DATA_W-1:0] b_q;
    logic                       exec;
    logic                       is_div;

    alu_pkg::alu_result_u       core_res;
    logic                       core_zero;
    logic                       core_neg;
    alu_pkg::alu_result_u       div_res;
    logic                       div_neg;
    logic                       div_done;

    assign is_div = (op_q == alu_pkg::OP_DIV);

    alu_core u_core (
        .op     (op_q),
        .a      (a_q),
        .b      (b_q),
        .result (core_res),
        .zero   (core_zero),
        .neg    (core_neg)
    );

    alu_divider u_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (exec && is_div),
        .a      (a_q),
        .b      (b_q),
        .result (div_res),
        .neg    (div_neg),
        .done   (div_done)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane.busy <= 1'b0;
            lane.done <= 1'b0;
            exec      <= 1'b0;
        end else begin
            exec <= lane.start;
            if (lane.start) begin
                lane.busy <= 1'b1;
            end
            if ((exec && !is_div) || div_done) begin
                lane.done <= 1'b1;
            end
            if (lane.rel) begin
                lane.busy <= 1'b0;
                lane.done <= 1'b0;
            end
        end
    end

    // Operands and result, held until the collector frees the lane
    always_ff @(posedge clk) begin
        if (lane.start) begin
            op_q <= lane.op;
            a_q  <= lane.a;
            b_q  <= lane.b;
        end
        if (exec && !is_div) begin
            lane.result <= core_res;
            lane.zero   <= core_zero;
            lane.neg    <= core_neg;
        end else if (div_done) begin
            lane.result <= div_res;
            lane.zero   <= (div_res.prod == '0);
            lane.neg    <= div_neg;
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module alu_dispatch (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       req,
    output logic                            ack,
    input  wire logic [alu_pkg::OP_W-1:0]   op,
    input  wire logic [alu_pkg::DATA_W-1:0] a,
    input  wire logic [alu_pkg::DATA_W-1:0] b,
    alu_lane_if.dispatch                    lanes [alu_pkg::NUM_LANES]
);

    localparam int PW = alu_pkg::LANE_IDX_W;

    logic [PW-1:0]                 ptr;
    logic [alu_pkg::NUM_LANES-1:0] busy_v;
    logic                          fire;

    // Issue only to a free lane, otherwise ack is held back
    assign fire = req && !ack && !busy_v[ptr];

    for (genvar i = 0; i < alu_pkg::NUM_LANES; i++) begin : g_lane
        assign busy_v[i]      = lanes[i].busy;
        assign lanes[i].start = fire && (ptr == PW'(i));
        // Request data is stable while req is high
        assign lanes[i].op    = op;
        assign lanes[i].a     = a;
        assign lanes[i].b     = b;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
            ptr <= '0;
        end else begin
            if (fire) begin
                ack <= 1'b1;
                ptr <= ptr + PW'(1);
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_collect.sv
`timescale 1ns/1ns
`default_nettype none

module alu_collect (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    alu_lane_if.collect                 lanes [alu_pkg::NUM_LANES],
    output logic                        res_req,
    input  wire logic                   res_ack,
    output logic [alu_pkg::DATA_W-1:0]  res_hi,
    output logic [alu_pkg::DATA_W-1:0]  res_lo,
    output logic                        res_zero,
    output logic                        res_neg
);

    localparam int PW = alu_pkg::LANE_IDX_W;

    logic [PW-1:0]                 ptr;
    logic [alu_pkg::NUM_LANES-1:0] done_v;
    logic [alu_pkg::NUM_LANES-1:0] zero_v;
    logic [alu_pkg::NUM_LANES-1:0] neg_v;
    alu_pkg::alu_result_u          result_v [alu_pkg::NUM_LANES];
    logic                          present;
    logic                          take;

    // Lane fields gathered so the pointer can select them
    for (genvar i = 0; i < alu_pkg::NUM_LANES; i++) begin : g_lane
        assign done_v[i]    = lanes[i].done;
        assign zero_v[i]    = lanes[i].zero;
        assign neg_v[i]     = lanes[i].neg;
        assign result_v[i]  = lanes[i].result;
        assign lanes[i].rel = take && (ptr == PW'(i));
    end

    // Next result only after the previous handshake is fully closed
    assign present = done_v[ptr] && !res_req && !res_ack;
    assign take    = res_req && res_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_req <= 1'b0;
            ptr     <= '0;
        end else begin
            if (present) begin
                res_req <= 1'b1;
            end else if (take) begin
                res_req <= 1'b0;
                ptr     <= ptr + PW'(1);
            end
        end
    end

    // Output words only load between handshakes
    always_ff @(posedge clk) begin
        if (present) begin
            res_hi   <= result_v[ptr].pair.hi;
            res_lo   <= result_v[ptr].pair.lo;
            res_zero <= zero_v[ptr];
            res_neg  <= neg_v[ptr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_array_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_array_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // Request port
    input  wire logic                       req,
    output logic                            ack,
    input  wire logic [alu_pkg::OP_W-1:0]   op,
    input  wire logic [alu_pkg::DATA_W-1:0] a,
    input  wire logic [alu_pkg::DATA_W-1:0] b,
    // Result port
    output logic                            res_req,
    input  wire logic                       res_ack,
    output logic [alu_pkg::DATA_W-1:0]      res_hi,
    output logic [alu_pkg::DATA_W-1:0]      res_lo,
    output logic                            res_zero,
    output logic                            res_neg
);

    alu_lane_if lane_bus [alu_pkg::NUM_LANES] ();

    alu_dispatch u_dispatch (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .ack   (ack),
        .op    (op),
        .a     (a),
        .b     (b),
        .lanes (lane_bus)
    );

    for (genvar i = 0; i < alu_pkg::NUM_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .lane  (lane_bus[i])
        );
    end

    alu_collect u_collect (
        .clk      (clk),
        .rst_n    (rst_n),
        .lanes    (lane_bus),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .res_hi   (res_hi),
        .res_lo   (res_lo),
        .res_zero (res_zero),
        .res_neg  (res_neg)
    );

endmodule

`default_nettype wire

// File: tb/alu_array_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_array_tb;

    localparam int MAX_LINES      = 64;
    localparam int CYCLES_PER_OP  = 200;
    localparam int W              = alu_pkg::DATA_W;

    logic                     clk;
    logic                     rst_n;
    logic                     req;
    logic                     ack;
    logic [alu_pkg::OP_W-1:0] op;
    logic [W-1:0]             a;
    logic [W-1:0]             b;
    logic                     res_req;
    logic                     res_ack;
    logic [W-1:0]             res_hi;
    logic [W-1:0]             res_lo;
    logic                     res_zero;
    logic                     res_neg;

    // Test vectors and expected results in issue order
    logic [alu_pkg::OP_W-1:0] op_mem   [MAX_LINES];
    logic [W-1:0]             a_mem    [MAX_LINES];
    logic [W-1:0]             b_mem    [MAX_LINES];
    logic [W-1:0]             exp_hi   [MAX_LINES];
    logic [W-1:0]             exp_lo   [MAX_LINES];
    logic                     exp_zero [MAX_LINES];
    logic                     exp_neg  [MAX_LINES];

    int                       num_lines;
    int                       checked;
    logic                     loaded;
    logic [31:0]              lfsr;

    alu_array_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ack      (ack),
        .op       (op),
        .a        (a),
        .b        (b),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .res_hi   (res_hi),
        .res_lo   (res_lo),
        .res_zero (res_zero),
        .res_neg  (res_neg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // Three LFSR bits give a delay of 0 to 7 cycles
    task automatic pick_delay(output logic [2:0] cycles);
        cycles = '0;
        for (int k = 0; k < 3; k++) begin
            cycles = {cycles[1:0], lfsr[0]};
            lfsr   = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_hi;
        logic [31:0] f_lo;
        logic [31:0] f_zero;
        logic [31:0] f_neg;
        fd = $fopen("tb/alu_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file tb/alu_testdata.txt");
            $display("Test FAILED");
            $fatal(1, "Missing test data");
        end else begin
            num_lines = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Lines starting with # describe the columns
                if (line.len() > 0 && line.getc(0) != "#" && num_lines < MAX_LINES) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                f_op, f_a, f_b, f_hi, f_lo, f_zero, f_neg);
                    if (n == 7) begin
                        op_mem[num_lines]   = f_op[alu_pkg::OP_W-1:0];
                        a_mem[num_lines]    = f_a;
                        b_mem[num_lines]    = f_b;
                        exp_hi[num_lines]   = f_hi;
                        exp_lo[num_lines]   = f_lo;
                        exp_zero[num_lines] = f_zero[0];
                        exp_neg[num_lines]  = f_neg[0];
                        num_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Request side of the four-phase handshake
    task automatic issue_all();
        for (int i = 0; i < num_lines; i++) begin
            @(posedge clk);
            #1;
            op  = op_mem[i];
            a   = a_mem[i];
            b   = b_mem[i];
            req = 1'b1;
            do begin
                @(posedge clk);
                #1;
            end while (!ack);
            req = 1'b0;
            do begin
                @(posedge clk);
                #1;
            end while (ack);
        end
    endtask

    // Result side of the four-phase handshake
    // Results must come back in issue order
    task automatic receive_all();
        logic [2:0] delay;
        for (int i = 0; i < num_lines; i++) begin
            do begin
                @(posedge clk);
                #1;
            end while (!res_req);
            check_value($sformatf("line %0d hi", i), res_hi, exp_hi[i]);
            check_value($sformatf("line %0d lo", i), res_lo, exp_lo[i]);
            check_value($sformatf("line %0d zero", i), {31'b0, res_zero}, {31'b0, exp_zero[i]});
            check_value($sformatf("line %0d neg", i), {31'b0, res_neg}, {31'b0, exp_neg[i]});
            checked++;
            pick_delay(delay);
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            res_ack = 1'b1;
            do begin
                @(posedge clk);
                #1;
            end while (res_req);
            res_ack = 1'b0;
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        req       = 1'b0;
        op        = '0;
        a         = '0;
        b         = '0;
        res_ack   = 1'b0;
        checked   = 0;
        num_lines = 0;
        loaded    = 1'b0;
        lfsr      = 32'h37c7;
        load_testdata();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            issue_all();
            receive_all();
        join
        // No further result may follow the last data line
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        if (num_lines > 0 && !res_req) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("No data lines were read, or the DUT sent more than %0d results",
                     num_lines);
            $display("Test FAILED");
            $fatal(1, "Incomplete run");
        end
    end

    // Watchdog sized by the number of operations
    initial begin
        wait (loaded);
        repeat (10 + num_lines * CYCLES_PER_OP) @(posedge clk);
        $display("Timeout: the results did not arrive, %0d of %0d checked", checked, num_lines);
        $display("Test FAILED");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// File: tb/alu_testdata.txt
# op a b exp_hi exp_lo exp_zero exp_neg, all fields hex
# one operation per line, results expected back in this order
7 00000064 00000007 0000000e 00000002 0 0
0 00000005 00000003 00000000 00000008 0 0
1 12345678 12345678 00000000 00000000 1 0
5 ff00ff00 0ff00ff0 00000000 0f000f00 0 0
7 ffffff9c 00000007 fffffff2 fffffffe 0 1
1 00000003 00000005 00000000 fffffffe 0 1
4 a5a5a5a5 a5a5a5a5 00000000 00000000 1 0
3 f0f0f0f0 0f0f0f0f 00000000 ffffffff 0 1
7 00000064 fffffff9 fffffff2 00000002 0 1
0 7fffffff 00000001 00000000 80000000 0 1
2 00000001 00000000 00000000 ffffffff 0 1
d 0000ffff 00000000 00000000 ffff0000 0 1
7 ffffff9c fffffff9 0000000e fffffffe 0 0
8 00000001 00000024 00000000 00000010 0 0
9 80000000 0000001f 00000000 00000001 0 0
a 80000000 00000004 00000000 f8000000 0 1
a 40000000 00000021 00000000 20000000 0 0
b 12345678 00000008 00000000 78123456 0 0
c 80000001 00000001 00000000 00000003 0 0
6 ffffffff ffffffff fffffffe 00000001 0 1
6 00010000 00010000 00000001 00000000 0 0
7 00000009 00000000 ffffffff 00000009 0 0
7 fffffff7 00000000 00000001 fffffff7 0 1
e 12345678 9abcdef0 00000000 00000000 1 0

// File: files.f
rtl/alu_pkg.sv
rtl/alu_lane_if.sv
rtl/alu_core.sv
rtl/alu_divider.sv
rtl/alu_lane.sv
rtl/alu_dispatch.sv
rtl/alu_collect.sv
rtl/alu_array_top.sv
tb/alu_array_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module alu_array_tb -f files.f -o alu_array_sim
./obj_dir/alu_array_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1
